// File: src/tile_pkg.sv
package tile_pkg;

    // 32-bit elements carried by one 256-bit beat.
    localparam int ELEMS_PER_BEAT = 8;

    typedef struct packed {
        logic [31:0] base_a;
        logic [31:0] base_b;
        logic [31:0] m;
        logic [31:0] k;
        logic [31:0] n;
        logic        a_mode;
        logic        b_mode;
    } gemm_cfg_t;

    // Raw bus word, or eight element lanes for masking.
    typedef union packed {
        logic [255:0]                    raw;
        logic [ELEMS_PER_BEAT-1:0][31:0] lane;
    } beat_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } row_req_t;

    typedef struct packed {
        logic  valid;
        beat_u data;
    } beat_rsp_t;

    typedef struct packed {
        logic       we;
        logic       sel_b;
        logic [7:0] row;
        logic [7:0] beat;
        beat_u      data;
    } tile_wr_t;

endpackage

// File: src/cfg_regs.sv
`timescale 1ns/10ps

module cfg_regs
    import tile_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        busy,
    output gemm_cfg_t   cfg,
    output logic        start
);

    logic served;
    logic take;

    // One ack per host access, then hold off until stb drops.
    assign take = wb_cyc && wb_stb && !served;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            served <= 1'b0;
            wb_ack <= 1'b0;
            start  <= 1'b0;
            cfg    <= '0;
        end else begin
            wb_ack <= take;
            start  <= take && wb_we && (wb_adr == 3'd6) && wb_dat_w[0] && !busy;
            if (!(wb_cyc && wb_stb)) begin
                served <= 1'b0;
            end else if (take) begin
                served <= 1'b1;
            end
            // Job registers are frozen while a job runs.
            if (take && wb_we && !busy) begin
                case (wb_adr)
                    3'd0: cfg.base_a <= wb_dat_w;
                    3'd1: cfg.base_b <= wb_dat_w;
                    3'd2: cfg.m      <= wb_dat_w;
                    3'd3: cfg.k      <= wb_dat_w;
                    3'd4: cfg.n      <= wb_dat_w;
                    3'd5: begin
                        cfg.a_mode <= wb_dat_w[0];
                        cfg.b_mode <= wb_dat_w[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data lines up with ack.
    always_ff @(posedge clk) begin
        if (take) begin
            case (wb_adr)
                3'd0:    wb_dat_r <= cfg.base_a;
                3'd1:    wb_dat_r <= cfg.base_b;
                3'd2:    wb_dat_r <= cfg.m;
                3'd3:    wb_dat_r <= cfg.k;
                3'd4:    wb_dat_r <= cfg.n;
                3'd5:    wb_dat_r <= {30'b0, cfg.b_mode, cfg.a_mode};
                3'd6:    wb_dat_r <= {31'b0, busy};
                default: wb_dat_r <= '0;
            endcase
        end
    end

endmodule

// File: src/tile_fetch_ctrl.sv
`timescale 1ns/10ps

module tile_fetch_ctrl
    import tile_pkg::*;
#(
    parameter int TILE = 16
) (
    input  logic      clk,
    input  logic      rstn,
    input  gemm_cfg_t cfg,
    input  logic      start,
    output logic      busy,
    output row_req_t  req,
    input  logic      rdr_idle,
    input  beat_rsp_t rsp,
    output tile_wr_t  wr,
    input  logic      full,
    output logic      pair_done
);

    localparam int BEATS = TILE / ELEMS_PER_BEAT;

    localparam logic [2:0] IDLE     = 3'd0;
    localparam logic [2:0] WAIT_BUF = 3'd1;
    localparam logic [2:0] LOAD_A   = 3'd2;
    localparam logic [2:0] FETCH_A  = 3'd3;
    localparam logic [2:0] LOAD_B   = 3'd4;
    localparam logic [2:0] FETCH_B  = 3'd5;

    logic [2:0]  state;
    logic [31:0] m_cnt;
    logic [31:0] n_cnt;
    logic [31:0] k_cnt;
    logic [7:0]  row_cnt;
    logic [7:0]  beat_cnt;
    logic        job_last;

    logic        cur_b;
    logic        elem_along_k;
    logic [31:0] row_k;
    logic [31:0] a_addr;
    logic [31:0] b_addr;
    logic        beat_last;
    logic        row_last;
    logic        k_last;
    logic        n_last;
    logic        m_last;
    logic        last_write;
    beat_u       pad_data;

    assign cur_b = (state == LOAD_B) || (state == FETCH_B);
    assign row_k = k_cnt + 32'(row_cnt);

    assign a_addr = cfg.a_mode ? cfg.base_a + cfg.k * (m_cnt + 32'(row_cnt)) + k_cnt
                               : cfg.base_a + cfg.m * row_k + m_cnt;
    assign b_addr = cfg.b_mode ? cfg.base_b + cfg.n * row_k + n_cnt
                               : cfg.base_b + cfg.k * (n_cnt + 32'(row_cnt)) + k_cnt;

    assign beat_last = beat_cnt == 8'(BEATS - 1);
    assign row_last  = row_cnt == 8'(TILE - 1);
    assign k_last    = k_cnt + 32'(TILE) >= cfg.k;
    assign n_last    = n_cnt + 32'(TILE) >= cfg.n;
    assign m_last    = m_cnt + 32'(TILE) >= cfg.m;

    assign last_write = wr.we && wr.sel_b && (wr.row == 8'(TILE - 1))
                        && (wr.beat == 8'(BEATS - 1));

    // A mode 1 and B mode 0 lay k along the row.
    assign elem_along_k = cur_b ? !cfg.b_mode : cfg.a_mode;

    always_comb begin
        logic [31:0] lane_k;
        pad_data = rsp.data;
        lane_k   = k_cnt + 32'(beat_cnt) * 32'(ELEMS_PER_BEAT);
        if (!elem_along_k) begin
            if (row_k >= cfg.k) begin
                pad_data.raw = '0;
            end
        end else begin
            for (int l = 0; l < ELEMS_PER_BEAT; l++) begin
                if (lane_k + 32'(l) >= cfg.k) begin
                    pad_data.lane[l] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= IDLE;
            busy      <= 1'b0;
            req.valid <= 1'b0;
            wr.we     <= 1'b0;
            pair_done <= 1'b0;
            m_cnt     <= '0;
            n_cnt     <= '0;
            k_cnt     <= '0;
            row_cnt   <= '0;
            beat_cnt  <= '0;
            job_last  <= 1'b0;
        end else begin
            req.valid <= 1'b0;
            wr.we     <= 1'b0;
            pair_done <= last_write;
            // Padding is applied on the way into the buffer.
            if (rsp.valid) begin
                wr.we    <= 1'b1;
                wr.sel_b <= cur_b;
                wr.row   <= row_cnt;
                wr.beat  <= beat_cnt;
                wr.data  <= pad_data;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        busy     <= 1'b1;
                        m_cnt    <= '0;
                        n_cnt    <= '0;
                        k_cnt    <= '0;
                        row_cnt  <= '0;
                        beat_cnt <= '0;
                        state    <= LOAD_A;
                    end
                end
                WAIT_BUF: begin
                    // Full lags the last write by two cycles.
                    if (!full && !pair_done && !wr.we) begin
                        if (job_last) begin
                            busy  <= 1'b0;
                            state <= IDLE;
                        end else begin
                            state <= LOAD_A;
                        end
                    end
                end
                LOAD_A, LOAD_B: begin
                    if (rdr_idle) begin
                        req.valid <= 1'b1;
                        req.addr  <= cur_b ? b_addr : a_addr;
                        state     <= cur_b ? FETCH_B : FETCH_A;
                    end
                end
                FETCH_A, FETCH_B: begin
                    if (rsp.valid) begin
                        beat_cnt <= beat_last ? '0 : beat_cnt + 8'd1;
                        if (beat_last) begin
                            row_cnt <= row_last ? '0 : row_cnt + 8'd1;
                            if (!row_last) begin
                                state <= cur_b ? LOAD_B : LOAD_A;
                            end else if (!cur_b) begin
                                state <= LOAD_B;
                            end else begin
                                // Pair complete. Step k, then n, then m.
                                state    <= WAIT_BUF;
                                job_last <= k_last && n_last && m_last;
                                k_cnt    <= k_last ? '0 : k_cnt + 32'(TILE);
                                if (k_last) begin
                                    n_cnt <= n_last ? '0 : n_cnt + 32'(TILE);
                                end
                                if (k_last && n_last) begin
                                    m_cnt <= m_last ? '0 : m_cnt + 32'(TILE);
                                end
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: src/beat_reader.sv
`timescale 1ns/10ps

module beat_reader
    import tile_pkg::*;
#(
    parameter int TILE = 16
) (
    input  logic         clk,
    input  logic         rstn,
    input  row_req_t     req,
    output logic         idle,
    output beat_rsp_t    rsp,
    output logic         mem_cyc,
    output logic         mem_stb,
    output logic [31:0]  mem_adr,
    input  logic         mem_ack,
    input  logic [255:0] mem_dat_r
);

    localparam int BEATS = TILE / ELEMS_PER_BEAT;

    logic [7:0] beat_cnt;
    logic       beat_done;

    assign beat_done = mem_stb && mem_ack;
    assign idle      = !mem_cyc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_cyc   <= 1'b0;
            mem_stb   <= 1'b0;
            rsp.valid <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            rsp.valid <= beat_done;
            if (beat_done) begin
                rsp.data.raw <= mem_dat_r;
            end
            if (!mem_cyc) begin
                if (req.valid) begin
                    mem_cyc  <= 1'b1;
                    mem_stb  <= 1'b1;
                    mem_adr  <= req.addr;
                    beat_cnt <= '0;
                end
            end else if (beat_done) begin
                // Drop stb for a cycle between beats.
                mem_stb <= 1'b0;
                if (beat_cnt == 8'(BEATS - 1)) begin
                    mem_cyc <= 1'b0;
                end else begin
                    beat_cnt <= beat_cnt + 8'd1;
                    mem_adr  <= mem_adr + 32'(ELEMS_PER_BEAT);
                end
            end else if (!mem_stb) begin
                mem_stb <= 1'b1;
            end
        end
    end

endmodule

// File: src/tile_buffer.sv
`timescale 1ns/10ps

module tile_buffer
    import tile_pkg::*;
#(
    parameter int TILE = 16
) (
    input  logic       clk,
    input  logic       rstn,
    input  tile_wr_t   wr,
    input  logic       pair_done,
    input  logic       tile_ack,
    output logic       full,
    input  logic       rd_sel_b,
    input  logic [7:0] rd_row,
    input  logic [7:0] rd_beat,
    output beat_u      rd_data
);

    localparam int BEATS = TILE / ELEMS_PER_BEAT;
    localparam int DEPTH = TILE * BEATS;
    localparam int AW    = $clog2(DEPTH);

    beat_u         mem_a [DEPTH];
    beat_u         mem_b [DEPTH];
    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;

    // Row-major, BEATS words per row.
    assign wr_idx = AW'(32'(wr.row) * 32'(BEATS) + 32'(wr.beat));
    assign rd_idx = AW'(32'(rd_row) * 32'(BEATS) + 32'(rd_beat));

    always_ff @(posedge clk) begin
        if (wr.we) begin
            if (wr.sel_b) begin
                mem_b[wr_idx] <= wr.data;
            end else begin
                mem_a[wr_idx] <= wr.data;
            end
        end
        rd_data <= rd_sel_b ? mem_b[rd_idx] : mem_a[rd_idx];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            full <= 1'b0;
        end else if (pair_done) begin
            full <= 1'b1;
        end else if (tile_ack) begin
            full <= 1'b0;
        end
    end

endmodule

// File: src/gemm_loader_top.sv
`timescale 1ns/10ps

module gemm_loader_top
    import tile_pkg::*;
#(
    parameter int TILE = 16
) (
    input  logic         clk,
    input  logic         rstn,
    input  logic         host_cyc,
    input  logic         host_stb,
    input  logic         host_we,
    input  logic [2:0]   host_adr,
    input  logic [31:0]  host_dat_w,
    output logic [31:0]  host_dat_r,
    output logic         host_ack,
    output logic         mem_cyc,
    output logic         mem_stb,
    output logic [31:0]  mem_adr,
    input  logic         mem_ack,
    input  logic [255:0] mem_dat_r,
    output logic         tile_ready,
    input  logic         tile_ack,
    input  logic         rd_sel_b,
    input  logic [7:0]   rd_row,
    input  logic [7:0]   rd_beat,
    output beat_u        rd_data,
    output logic         busy
);

    gemm_cfg_t cfg;
    logic      start;
    row_req_t  req;
    logic      rdr_idle;
    beat_rsp_t rsp;
    tile_wr_t  wr;
    logic      pair_done;

    cfg_regs cfg_regs_i (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (host_cyc),
        .wb_stb   (host_stb),
        .wb_we    (host_we),
        .wb_adr   (host_adr),
        .wb_dat_w (host_dat_w),
        .wb_dat_r (host_dat_r),
        .wb_ack   (host_ack),
        .busy     (busy),
        .cfg      (cfg),
        .start    (start)
    );

    tile_fetch_ctrl #(
        .TILE (TILE)
    ) tile_fetch_ctrl_i (
        .clk       (clk),
        .rstn      (rstn),
        .cfg       (cfg),
        .start     (start),
        .busy      (busy),
        .req       (req),
        .rdr_idle  (rdr_idle),
        .rsp       (rsp),
        .wr        (wr),
        .full      (tile_ready),
        .pair_done (pair_done)
    );

    beat_reader #(
        .TILE (TILE)
    ) beat_reader_i (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .idle      (rdr_idle),
        .rsp       (rsp),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_adr   (mem_adr),
        .mem_ack   (mem_ack),
        .mem_dat_r (mem_dat_r)
    );

    tile_buffer #(
        .TILE (TILE)
    ) tile_buffer_i (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .pair_done (pair_done),
        .tile_ack  (tile_ack),
        .full      (tile_ready),
        .rd_sel_b  (rd_sel_b),
        .rd_row    (rd_row),
        .rd_beat   (rd_beat),
        .rd_data   (rd_data)
    );

endmodule

// File: tb/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model
    import tile_pkg::*;
#(
    parameter int WORDS    = 4096,
    parameter int MAX_WAIT = 3
) (
    input  logic         clk,
    input  logic         rstn,
    input  logic         cyc,
    input  logic         stb,
    input  logic [31:0]  adr,
    output logic         ack,
    output logic [255:0] dat_r,
    output int           adr_errors
);

    localparam int AW = $clog2(WORDS);

    // Element storage, filled by the testbench top.
    logic [31:0] mem [WORDS];

    logic        ack_q     = 1'b0;
    beat_u       dat_q     = '0;
    logic        pending   = 1'b0;
    logic [31:0] held_adr  = '0;
    int          wait_left = 0;
    int          errs      = 0;

    assign ack        = ack_q;
    assign dat_r      = dat_q.raw;
    assign adr_errors = errs;

    always @(posedge clk) begin
        int w;
        if (!rstn) begin
            ack_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (cyc && stb && !ack_q) begin
                if (!pending) begin
                    w = int'($urandom_range(MAX_WAIT, 0));
                    held_adr <= adr;
                end else begin
                    w = wait_left;
                    if (adr !== held_adr) begin
                        $display("Memory address changed from 0x%08h to 0x%08h before ack",
                                 held_adr, adr);
                        errs <= errs + 1;
                    end
                end
                if (w == 0) begin
                    ack_q   <= 1'b1;
                    pending <= 1'b0;
                    for (int j = 0; j < ELEMS_PER_BEAT; j++) begin
                        dat_q.lane[3'(j)] <= mem[AW'(adr + 32'(j))];
                    end
                end else begin
                    pending   <= 1'b1;
                    wait_left <= w - 1;
                end
            end else if (pending) begin
                $display("Memory strobe dropped at 0x%08h before ack", held_adr);
                errs    <= errs + 1;
                pending <= 1'b0;
            end
        end
    end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/10ps

module tb_top
    import tile_pkg::*;
();

    localparam int TILE      = 16;
    localparam int BEATS     = TILE / ELEMS_PER_BEAT;
    localparam int MEM_AW    = 12;
    localparam int MEM_WORDS = 1 << MEM_AW;
    localparam int MAX_WAIT  = 3;
    localparam int BASE_A    = 'h100;
    localparam int BASE_B    = 'h900;
    localparam int DIM_M     = 32;
    localparam int DIM_N     = 32;
    localparam int NJOBS     = 6;

    // Bit 0 is a_mode, bit 1 is b_mode.
    localparam int         JOB_K    [NJOBS] = '{32, 32, 32, 32, 40, 40};
    localparam logic [1:0] JOB_MODE [NJOBS] = '{2'b00, 2'b01, 2'b10, 2'b11, 2'b00, 2'b11};

    logic         clk = 1'b0;
    logic         rstn;
    logic         host_cyc;
    logic         host_stb;
    logic         host_we;
    logic [2:0]   host_adr;
    logic [31:0]  host_dat_w;
    logic [31:0]  host_dat_r;
    logic         host_ack;
    logic         mem_cyc;
    logic         mem_stb;
    logic [31:0]  mem_adr;
    logic         mem_ack;
    logic [255:0] mem_dat_r;
    logic         tile_ready;
    logic         tile_ack;
    logic         rd_sel_b;
    logic [7:0]   rd_row;
    logic [7:0]   rd_beat;
    beat_u        rd_data;
    logic         busy;
    int           mem_errors;

    logic [31:0]  ref_mem [MEM_WORDS];
    int           errors;
    int           cur_k;
    logic         cur_a_mode;
    logic         cur_b_mode;

    always #10 clk = ~clk;

    gemm_loader_top #(
        .TILE (TILE)
    ) gemm_loader_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .host_cyc   (host_cyc),
        .host_stb   (host_stb),
        .host_we    (host_we),
        .host_adr   (host_adr),
        .host_dat_w (host_dat_w),
        .host_dat_r (host_dat_r),
        .host_ack   (host_ack),
        .mem_cyc    (mem_cyc),
        .mem_stb    (mem_stb),
        .mem_adr    (mem_adr),
        .mem_ack    (mem_ack),
        .mem_dat_r  (mem_dat_r),
        .tile_ready (tile_ready),
        .tile_ack   (tile_ack),
        .rd_sel_b   (rd_sel_b),
        .rd_row     (rd_row),
        .rd_beat    (rd_beat),
        .rd_data    (rd_data),
        .busy       (busy)
    );

    tb_mem_model #(
        .WORDS    (MEM_WORDS),
        .MAX_WAIT (MAX_WAIT)
    ) mem_model_i (
        .clk        (clk),
        .rstn       (rstn),
        .cyc        (mem_cyc),
        .stb        (mem_stb),
        .adr        (mem_adr),
        .ack        (mem_ack),
        .dat_r      (mem_dat_r),
        .adr_errors (mem_errors)
    );

    function automatic int pairs_for(input int k);
        return (DIM_M / TILE) * (DIM_N / TILE) * ((k + TILE - 1) / TILE);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected 0x%08h, got 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    // Element c of row r in the A or B tile, padding included.
    function automatic logic [31:0] expected_elem(input logic sel_b, input int r, input int c,
                                                  input int kt, input int nt, input int mt);
        int kk;
        int addr;
        if (!sel_b) begin
            if (!cur_a_mode) begin
                kk   = kt + r;
                addr = BASE_A + DIM_M * kk + mt + c;
            end else begin
                kk   = kt + c;
                addr = BASE_A + cur_k * (mt + r) + kk;
            end
        end else begin
            if (!cur_b_mode) begin
                kk   = kt + c;
                addr = BASE_B + cur_k * (nt + r) + kk;
            end else begin
                kk   = kt + r;
                addr = BASE_B + DIM_N * kk + nt + c;
            end
        end
        if (kk >= cur_k) begin
            return '0;
        end
        return ref_mem[MEM_AW'(addr)];
    endfunction

    task automatic host_access(input logic we, input logic [2:0] a, input logic [31:0] d,
                               output logic [31:0] rdata);
        int waited;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = we;
        host_adr   = a;
        host_dat_w = d;
        waited     = 0;
        @(posedge clk);
        #1;
        while (!host_ack && waited < 16) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!host_ack) begin
            $display("Host access to register %0d was never acknowledged", a);
            errors++;
        end
        rdata = host_dat_r;
        #1;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic host_write(input logic [2:0] a, input logic [31:0] d);
        logic [31:0] unused;
        host_access(1'b1, a, d, unused);
    endtask

    task automatic host_read(input logic [2:0] a, output logic [31:0] d);
        host_access(1'b0, a, '0, d);
    endtask

    // One full sweep over both tiles of the buffer.
    task automatic read_pair(input int kt, input int nt, input int mt);
        int c;
        for (int s = 0; s < 2; s++) begin
            for (int r = 0; r < TILE; r++) begin
                for (int b = 0; b < BEATS; b++) begin
                    rd_sel_b = (s == 1);
                    rd_row   = 8'(r);
                    rd_beat  = 8'(b);
                    @(posedge clk);
                    #1;
                    for (int j = 0; j < ELEMS_PER_BEAT; j++) begin
                        c = b * ELEMS_PER_BEAT + j;
                        check_value($sformatf("rd_data %s[%0d][%0d]", s == 1 ? "B" : "A", r, c),
                                    expected_elem(s == 1, r, c, kt, nt, mt),
                                    rd_data.lane[3'(j)]);
                    end
                    #1;
                end
            end
        end
    endtask

    task automatic check_frozen();
        logic [31:0] v;
        logic [31:0] want [6];
        want[0] = 32'(BASE_A);
        want[1] = 32'(BASE_B);
        want[2] = 32'(DIM_M);
        want[3] = 32'(cur_k);
        want[4] = 32'(DIM_N);
        want[5] = {30'b0, cur_b_mode, cur_a_mode};
        for (int i = 0; i < 6; i++) begin
            host_write(3'(i), $urandom);
        end
        for (int i = 0; i < 6; i++) begin
            host_read(3'(i), v);
            check_value($sformatf("reg%0d while busy", i), want[3'(i)], v);
        end
    endtask

    task automatic run_job(input int idx);
        int          npairs;
        int          k_steps;
        int          n_steps;
        int          delay;
        int          waited;
        int          kt;
        int          nt;
        int          mt;
        logic        long_ack;
        logic [31:0] v;
        cur_k      = JOB_K[3'(idx)];
        cur_a_mode = JOB_MODE[3'(idx)][0];
        cur_b_mode = JOB_MODE[3'(idx)][1];
        long_ack   = (idx == NJOBS - 1);
        k_steps    = (cur_k + TILE - 1) / TILE;
        n_steps    = DIM_N / TILE;
        npairs     = pairs_for(cur_k);
        host_write(3'd0, 32'(BASE_A));
        host_write(3'd1, 32'(BASE_B));
        host_write(3'd2, 32'(DIM_M));
        host_write(3'd3, 32'(cur_k));
        host_write(3'd4, 32'(DIM_N));
        host_write(3'd5, {30'b0, cur_b_mode, cur_a_mode});
        host_write(3'd6, 32'd1);
        host_read(3'd6, v);
        check_value("busy", 32'd1, v);
        if (idx == 0) begin
            check_frozen();
        end
        for (int p = 0; p < npairs; p++) begin
            @(posedge clk);
            #1;
            while (!tile_ready && busy) begin
                @(posedge clk);
                #1;
            end
            if (!tile_ready) begin
                $display("Job %0d ended after %0d of %0d tile pairs", idx, p, npairs);
                errors++;
                #1;
                return;
            end
            check_value("busy", 32'd1, {31'b0, busy});
            // Order is k innermost, then n, then m.
            kt = (p % k_steps) * TILE;
            nt = ((p / k_steps) % n_steps) * TILE;
            mt = (p / (k_steps * n_steps)) * TILE;
            #1;
            read_pair(kt, nt, mt);
            delay = long_ack ? int'($urandom_range(200, 100)) : int'($urandom_range(8, 0));
            repeat (delay + 1) @(posedge clk);
            #2;
            check_value("tile_ready", 32'd1, {31'b0, tile_ready});
            check_value("busy", 32'd1, {31'b0, busy});
            read_pair(kt, nt, mt);
            tile_ack = 1'b1;
            @(posedge clk);
            #2;
            tile_ack = 1'b0;
        end
        waited = 0;
        @(posedge clk);
        #1;
        while (busy && !tile_ready && waited < 64) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (tile_ready) begin
            $display("Job %0d delivered more than %0d tile pairs", idx, npairs);
            errors++;
        end else if (busy) begin
            $display("Job %0d stayed busy after its last tile pair", idx);
            errors++;
        end
        #1;
    endtask

    initial begin
        int limit;
        limit = 4000;
        for (int i = 0; i < NJOBS; i++) begin
            limit += pairs_for(JOB_K[3'(i)])
                     * (2 * TILE * TILE / ELEMS_PER_BEAT * (MAX_WAIT + 8) + 512);
        end
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int unsigned seed;
        logic [31:0] v;
        logic [31:0] vals [6];
        seed = 32'h8cd9_7b8e;
        void'($urandom(seed));
        errors     = 0;
        rstn       = 1'b0;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        tile_ack   = 1'b0;
        rd_sel_b   = 1'b0;
        rd_row     = '0;
        rd_beat    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            v = $urandom;
            ref_mem[MEM_AW'(i)]           = v;
            mem_model_i.mem[MEM_AW'(i)] = v;
        end
        repeat (10) @(posedge clk);
        #1;
        // Outputs held low by reset.
        check_value("busy", 32'd0, {31'b0, busy});
        check_value("tile_ready", 32'd0, {31'b0, tile_ready});
        check_value("mem_cyc", 32'd0, {31'b0, mem_cyc});
        check_value("mem_stb", 32'd0, {31'b0, mem_stb});
        check_value("host_ack", 32'd0, {31'b0, host_ack});
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #2;

        // Register readback before any job.
        for (int i = 0; i < 6; i++) begin
            vals[3'(i)] = $urandom;
            host_write(3'(i), vals[3'(i)]);
        end
        vals[5] = {30'b0, vals[5][1:0]};
        for (int i = 0; i < 6; i++) begin
            host_read(3'(i), v);
            check_value($sformatf("reg%0d", i), vals[3'(i)], v);
        end
        host_read(3'd6, v);
        check_value("busy", 32'd0, v);

        for (int j = 0; j < NJOBS; j++) begin
            run_job(j);
        end

        $display("Checks done: %0d check errors, %0d memory bus errors", errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
src/tile_pkg.sv
src/cfg_regs.sv
src/tile_fetch_ctrl.sv
src/beat_reader.sv
src/tile_buffer.sv
src/gemm_loader_top.sv
tb/tb_mem_model.sv
tb/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
FAIL_MSG  ?= Simulation finished: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
